// ==== all.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/cpu.sv
sim/cpu_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu import isa_pkg::*, ctrl_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e alu_op,
    input  func_e   func,
    input  opcode_e opcode,
    output word_t   result,
    output logic    bcond
);

    word_t func_result;

    always_comb begin
        case (opcode)
            OP_ORI: func_result = a | b;
            OP_LHI: func_result = b << 8;
            // Branch target, a is pc and b the offset
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: func_result = a + b + word_t'(1);
            default: begin
                case (func)
                    FN_ADD:  func_result = a + b;
                    FN_SUB:  func_result = a - b;
                    FN_AND:  func_result = a & b;
                    FN_ORR:  func_result = a | b;
                    FN_NOT:  func_result = ~a;
                    FN_TCP:  func_result = ~a + word_t'(1);
                    FN_SHL:  func_result = a << 1;
                    // Arithmetic shift keeps the sign
                    FN_SHR:  func_result = word_t'($signed(a) >>> 1);
                    default: func_result = a + b;
                endcase
            end
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_FUNC: result = func_result;
            default:  result = a + b;
        endcase
    end

    // High means the branch is taken
    always_comb begin
        case (opcode)
            OP_BNE:  bcond = (a != b);
            OP_BEQ:  bcond = (a == b);
            OP_BGZ:  bcond = ($signed(a) > 0);
            OP_BLZ:  bcond = ($signed(a) < 0);
            default: bcond = 1'b0;
        endcase
    end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ns

module control_unit import isa_pkg::*, ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  opcode_e opcode,
    input  func_e   func,
    input  logic    bcond,
    output logic    pc_write,
    output logic    pc_write_cond,
    output logic    i_or_d,
    output logic    read_m,
    output logic    write_m,
    output logic    ir_write,
    output logic    mem_to_reg,
    output logic    reg_write,
    output logic    pc_to_reg,
    output logic    output_en,
    output logic    halted,
    output logic    new_inst,
    output src_a_e  src_a,
    output src_b_e  src_b,
    output alu_op_e alu_op,
    output pc_src_e pc_src
);

    state_e state;
    state_e next_state;

    logic is_rtype;
    logic is_itype;
    logic is_zext_imm;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jump;
    logic is_link;
    logic is_wwd;
    logic is_hlt;

    //////////////////////////////
    // Instruction classes
    always_comb begin
        is_rtype    = 1'b0;
        is_itype    = 1'b0;
        is_zext_imm = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        is_link     = 1'b0;
        is_wwd      = 1'b0;
        is_hlt      = 1'b0;
        case (opcode)
            OP_ADI: is_itype = 1'b1;
            OP_ORI, OP_LHI: begin
                is_itype    = 1'b1;
                is_zext_imm = 1'b1;
            end
            OP_LWD: is_load = 1'b1;
            OP_SWD: is_store = 1'b1;
            OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: is_branch = 1'b1;
            OP_JMP: is_jump = 1'b1;
            OP_JAL: begin
                is_jump = 1'b1;
                is_link = 1'b1;
            end
            // Shared with the register jump group
            OP_ALU: begin
                case (func)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR,
                    FN_NOT, FN_TCP, FN_SHL, FN_SHR: is_rtype = 1'b1;
                    FN_JPR: is_jump = 1'b1;
                    FN_JRL: begin
                        is_jump = 1'b1;
                        is_link = 1'b1;
                    end
                    FN_WWD: is_wwd = 1'b1;
                    FN_HLT: is_hlt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    //////////////////////////////
    // State register
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= IF_1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = IF_1;
        case (state)
            IF_1: next_state = IF_2;
            IF_2: next_state = ID;
            ID:   next_state = EX_1;
            EX_1: begin
                if (is_hlt) begin
                    next_state = EX_1;
                end else if (is_jump) begin
                    next_state = IF_1;
                end else if (is_branch) begin
                    // Taken branch needs a second cycle for the target
                    next_state = bcond ? EX_2 : IF_1;
                end else if (is_load || is_store) begin
                    next_state = MEM_1;
                end else begin
                    next_state = WB;
                end
            end
            EX_2:  next_state = IF_1;
            MEM_1: next_state = MEM_2;
            MEM_2: next_state = is_load ? WB : IF_1;
            WB:    next_state = IF_1;
            default: next_state = IF_1;
        endcase
    end

    //////////////////////////////
    // Strobes per state
    always_comb begin
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        i_or_d        = 1'b0;
        read_m        = 1'b0;
        write_m       = 1'b0;
        ir_write      = 1'b0;
        mem_to_reg    = 1'b0;
        reg_write     = 1'b0;
        pc_to_reg     = 1'b0;
        output_en     = 1'b0;
        // ALU idles on pc + 1
        src_a         = SRC_A_PC;
        src_b         = SRC_B_ONE;
        alu_op        = ALU_ADD;
        pc_src        = PC_SRC_ALU;
        case (state)
            IF_1: read_m = 1'b1;
            IF_2: ir_write = 1'b1;
            EX_1: begin
                if (is_rtype) begin
                    src_a  = SRC_A_REG;
                    src_b  = SRC_B_REG;
                    alu_op = ALU_FUNC;
                end else if (is_itype) begin
                    src_a  = SRC_A_REG;
                    src_b  = is_zext_imm ? SRC_B_ZEXT : SRC_B_SEXT;
                    alu_op = is_zext_imm ? ALU_FUNC : ALU_ADD;
                end else if (is_load || is_store) begin
                    src_a = SRC_A_REG;
                    src_b = SRC_B_SEXT;
                end else if (is_branch) begin
                    // alu_out still holds pc + 1 from ID
                    src_a         = SRC_A_REG;
                    src_b         = SRC_B_REG;
                    alu_op        = ALU_SUB;
                    pc_write_cond = 1'b1;
                    pc_src        = PC_SRC_ALU_OUT;
                end else if (is_jump) begin
                    pc_write  = 1'b1;
                    pc_src    = PC_SRC_JUMP;
                    reg_write = is_link;
                    pc_to_reg = is_link;
                end
                output_en = is_wwd;
            end
            EX_2: begin
                // pc + 1 + offset
                src_b    = SRC_B_SEXT;
                alu_op   = ALU_FUNC;
                pc_write = 1'b1;
            end
            MEM_1: begin
                i_or_d  = 1'b1;
                read_m  = is_load;
                write_m = is_store;
            end
            MEM_2: pc_write = is_store;
            WB: begin
                pc_write   = 1'b1;
                reg_write  = is_rtype || is_itype || is_load;
                mem_to_reg = is_load;
            end
            default: ;
        endcase
    end

    assign halted   = (state == EX_1) && is_hlt;
    assign new_inst = (state == IF_1);

    // One memory access per cycle
    assert property (@(posedge clk) disable iff (!reset_n) !(read_m && write_m));

    // Only reset leaves the halt state
    assert property (@(posedge clk) disable iff (!reset_n) halted |=> halted);

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/1ns

module cpu import isa_pkg::*, ctrl_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    output word_t address,
    output logic  read_m,
    output logic  write_m,
    output word_t write_data,
    input  word_t read_data,
    output word_t output_port,
    output logic  output_valid,
    output logic  halted,
    output logic  new_inst
);

    opcode_e opcode;
    func_e   func;
    logic    bcond;
    logic    pc_write;
    logic    pc_write_cond;
    logic    i_or_d;
    logic    ir_write;
    logic    mem_to_reg;
    logic    reg_write;
    logic    pc_to_reg;
    src_a_e  src_a;
    src_b_e  src_b;
    alu_op_e alu_op;
    pc_src_e pc_src;

    control_unit control_unit_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .opcode        (opcode),
        .func          (func),
        .bcond         (bcond),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .i_or_d        (i_or_d),
        .read_m        (read_m),
        .write_m       (write_m),
        .ir_write      (ir_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .pc_to_reg     (pc_to_reg),
        .output_en     (output_valid),
        .halted        (halted),
        .new_inst      (new_inst),
        .src_a         (src_a),
        .src_b         (src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src)
    );

    // wwd strobe doubles as the output port valid
    datapath datapath_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .pc_write      (pc_write),
        .pc_write_cond (pc_write_cond),
        .i_or_d        (i_or_d),
        .read_m        (read_m),
        .write_m       (write_m),
        .ir_write      (ir_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .pc_to_reg     (pc_to_reg),
        .output_en     (output_valid),
        .src_a         (src_a),
        .src_b         (src_b),
        .alu_op        (alu_op),
        .pc_src        (pc_src),
        .read_data     (read_data),
        .opcode        (opcode),
        .func          (func),
        .bcond         (bcond),
        .address       (address),
        .write_data    (write_data),
        .output_port   (output_port)
    );

endmodule

// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width
`define CPU_WORD_BITS    16

// General register count and index width
`define CPU_NUM_REGS     4
`define CPU_REG_IDX_BITS 2

// First fetch address after reset
`define CPU_RESET_PC     16'h0000

`endif

// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [2:0] {
        IF_1,
        IF_2,
        ID,
        EX_1,
        EX_2,
        MEM_1,
        MEM_2,
        WB
    } state_e;

    // ALU_FUNC defers to func, or to opcode for ori, lhi and branch targets
    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_SUB  = 2'b01,
        ALU_FUNC = 2'b10
    } alu_op_e;

    typedef enum logic {
        SRC_A_PC  = 1'b0,
        SRC_A_REG = 1'b1
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_REG  = 2'b00,
        SRC_B_ONE  = 2'b01,
        SRC_B_SEXT = 2'b10,
        SRC_B_ZEXT = 2'b11
    } src_b_e;

    typedef enum logic [1:0] {
        PC_SRC_ALU     = 2'b00,
        PC_SRC_ALU_OUT = 2'b01,
        PC_SRC_JUMP    = 2'b10
    } pc_src_e;

endpackage

// ==== hdl/datapath.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module datapath import isa_pkg::*, ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    pc_write,
    input  logic    pc_write_cond,
    input  logic    i_or_d,
    input  logic    read_m,
    input  logic    write_m,
    input  logic    ir_write,
    input  logic    mem_to_reg,
    input  logic    reg_write,
    input  logic    pc_to_reg,
    input  logic    output_en,
    input  src_a_e  src_a,
    input  src_b_e  src_b,
    input  alu_op_e alu_op,
    input  pc_src_e pc_src,
    input  word_t   read_data,
    output opcode_e opcode,
    output func_e   func,
    output logic    bcond,
    output word_t   address,
    output word_t   write_data,
    output word_t   output_port
);

    word_t    pc;
    word_t    ir;
    word_t    mdr;
    word_t    reg_a;
    word_t    reg_b;
    word_t    alu_out;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    rf_read_1;
    word_t    rf_read_2;
    word_t    rf_write_data;
    word_t    imm_sext;
    word_t    imm_zext;
    word_t    jump_target;
    word_t    pc_next;
    reg_idx_t write_idx;
    logic     read_pending;
    logic     pc_update;

    //////////////////////////////
    // Instruction fields
    assign opcode   = opcode_e'(ir[15:12]);
    assign func     = func_e'(ir[5:0]);
    assign imm_sext = {{8{ir[7]}}, ir[7:0]};
    assign imm_zext = {8'h00, ir[7:0]};

    // jpr and jrl jump to rs, jmp and jal stay in the current 4K page
    assign jump_target = (opcode == OP_JPR_GROUP) ? reg_a : {pc[15:12], ir[11:0]};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc           <= `CPU_RESET_PC;
            ir           <= '0;
            read_pending <= 1'b0;
        end else begin
            read_pending <= read_m;
            if (pc_update) begin
                pc <= pc_next;
            end
            if (ir_write) begin
                ir <= read_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        reg_a   <= rf_read_1;
        reg_b   <= rf_read_2;
        alu_out <= alu_result;
        // Memory answers one cycle after the strobe
        if (read_pending) begin
            mdr <= read_data;
        end
    end

    //////////////////////////////
    // Operand and pc selection
    assign alu_a = (src_a == SRC_A_REG) ? reg_a : pc;

    always_comb begin
        case (src_b)
            SRC_B_REG:  alu_b = reg_b;
            SRC_B_ONE:  alu_b = word_t'(1);
            SRC_B_SEXT: alu_b = imm_sext;
            SRC_B_ZEXT: alu_b = imm_zext;
            default:    alu_b = reg_b;
        endcase
    end

    always_comb begin
        case (pc_src)
            PC_SRC_ALU:     pc_next = alu_result;
            PC_SRC_ALU_OUT: pc_next = alu_out;
            PC_SRC_JUMP:    pc_next = jump_target;
            default:        pc_next = alu_result;
        endcase
    end

    // Conditional write fires on a branch that falls through
    assign pc_update = pc_write || (pc_write_cond && !bcond);

    //////////////////////////////
    // Write-back
    // Link value is pc + 1, left in alu_out by ID
    assign rf_write_data = mem_to_reg ? mdr : alu_out;

    always_comb begin
        if (pc_to_reg) begin
            write_idx = LINK_REG;
        end else if (opcode == OP_ALU) begin
            write_idx = ir[7:6];
        end else begin
            write_idx = ir[9:8];
        end
    end

    assign address     = i_or_d ? alu_out : pc;
    assign write_data  = write_m ? reg_b : '0;
    assign output_port = output_en ? reg_a : '0;

    register_file register_file_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .read_idx_1  (ir[11:10]),
        .read_idx_2  (ir[9:8]),
        .write_idx   (write_idx),
        .write_en    (reg_write),
        .write_data  (rf_write_data),
        .read_data_1 (rf_read_1),
        .read_data_2 (rf_read_2)
    );

    alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .alu_op (alu_op),
        .func   (func),
        .opcode (opcode),
        .result (alu_result),
        .bcond  (bcond)
    );

endmodule

// ==== hdl/isa_pkg.sv ====
`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`CPU_WORD_BITS-1:0]    word_t;
    typedef logic [`CPU_REG_IDX_BITS-1:0] reg_idx_t;

    // Instruction bits 15..12
    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_BGZ = 4'd2,
        OP_BLZ = 4'd3,
        OP_ADI = 4'd4,
        OP_ORI = 4'd5,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_JMP = 4'd9,
        OP_JAL = 4'd10,
        OP_ALU = 4'd15
    } opcode_e;

    // jpr, jrl, wwd and hlt sit on the R-type opcode, func tells them apart
    localparam opcode_e OP_JPR_GROUP = OP_ALU;

    // Instruction bits 5..0
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    // jal and jrl write the return address here
    localparam reg_idx_t LINK_REG = 2'd2;

endpackage

// ==== hdl/register_file.sv ====
`timescale 1ns/1ns

`include "cpu_consts.svh"

module register_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read_idx_1,
    input  reg_idx_t read_idx_2,
    input  reg_idx_t write_idx,
    input  logic     write_en,
    input  word_t    write_data,
    output word_t    read_data_1,
    output word_t    read_data_2
);

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_idx] <= write_data;
        end
    end

    // Reads see the old value during a write
    assign read_data_1 = regs[read_idx_1];
    assign read_data_2 = regs[read_idx_2];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module cpu_tb -Mdir obj_dir

sim_output=$(./obj_dir/Vcpu_tb)
echo "$sim_output"

if echo "$sim_output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import isa_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    IMAGE_WORDS  = 256;
    localparam int    DATA_WORDS   = 512;
    localparam int    EXPECT_BASE  = 'h100;
    localparam int    INFO_BASE    = 'h1f0;
    localparam int    NUM_SECTIONS = 4;
    localparam word_t END_MARKER   = 16'hdead;
    localparam int    WATCHDOG_NS  = (IMAGE_WORDS * 8 + 5) * CLK_PERIOD;
    localparam string DATA_FILE    = "sim/cpu_testdata.txt";

    logic  clk;
    logic  reset_n;
    word_t address;
    logic  read_m;
    logic  write_m;
    word_t write_data;
    word_t read_data;
    word_t output_port;
    logic  output_valid;
    logic  halted;
    logic  new_inst;

    word_t tdata [DATA_WORDS];
    word_t mem [IMAGE_WORDS];
    word_t expected [$];
    int    section_end [NUM_SECTIONS];
    word_t halt_addr;
    word_t inst_count_exp;
    word_t store_addr;
    word_t store_value;

    word_t last_read_addr = '0;
    logic  halt_seen      = 1'b0;
    int    inst_count     = 0;
    int    out_idx        = 0;
    int    section        = 0;
    int    section_errors = 0;
    int    late_outputs   = 0;
    int    extra_outputs  = 0;
    int    pass_count     = 0;
    int    fail_count     = 0;

    cpu cpu_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .address      (address),
        .read_m       (read_m),
        .write_m      (write_m),
        .write_data   (write_data),
        .read_data    (read_data),
        .output_port  (output_port),
        .output_valid (output_valid),
        .halted       (halted),
        .new_inst     (new_inst)
    );

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "ALU and immediate";
            1:       return "load and store";
            2:       return "branches";
            3:       return "jumps and links";
            default: return "halt";
        endcase
    endfunction

    task automatic load_image();
        int i;
        int sum;
        // Address-dependent fill shows up clearly if the core strays
        for (i = 0; i < DATA_WORDS; i++) begin
            tdata[i] = word_t'(i * 32'h0101) ^ 16'ha5c3;
        end
        $readmemh(DATA_FILE, tdata);
        for (i = 0; i < IMAGE_WORDS; i++) begin
            mem[i] <= tdata[i];
        end
        i = EXPECT_BASE;
        while (i < INFO_BASE && tdata[i] != END_MARKER) begin
            expected.push_back(tdata[i]);
            i++;
        end
        halt_addr      = tdata[INFO_BASE];
        inst_count_exp = tdata[INFO_BASE + 1];
        store_addr     = tdata[INFO_BASE + 2];
        store_value    = tdata[INFO_BASE + 3];
        sum = 0;
        for (i = 0; i < NUM_SECTIONS; i++) begin
            sum += int'(tdata[INFO_BASE + 4 + i]);
            section_end[i] = sum;
        end
    endtask

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, errors);
        end
    endtask

    task automatic close_section();
        // The stored word must also sit in memory
        if (section == 1 && mem[store_addr[7:0]] != store_value) begin
            $display("Mismatch mem[%h]: expected %h, got %h",
                     store_addr, store_value, mem[store_addr[7:0]]);
            section_errors++;
        end
        report_test(test_name(section), section_errors);
        section_errors = 0;
        section++;
    endtask

    task automatic check_output(input word_t value);
        if (out_idx >= expected.size()) begin
            $display("Unexpected wwd output %h after the last expected value", value);
            extra_outputs++;
        end else begin
            if (value != expected[out_idx]) begin
                $display("Mismatch output_port (output %0d): expected %h, got %h",
                         out_idx, expected[out_idx], value);
                section_errors++;
            end
            out_idx++;
            if (section < NUM_SECTIONS && out_idx == section_end[section]) begin
                close_section();
            end
        end
    endtask

    task automatic close_open_sections();
        while (section < NUM_SECTIONS) begin
            $display("%s: only %0d of %0d outputs seen before halt",
                     test_name(section), out_idx, section_end[section]);
            section_errors++;
            close_section();
        end
    endtask

    task automatic check_halt();
        int errors;
        errors = 0;
        if (!halted) begin
            $display("The core left the halt state");
            errors++;
        end
        if (last_read_addr != halt_addr) begin
            $display("Mismatch address at halt: expected %h, got %h", halt_addr, last_read_addr);
            errors++;
        end
        if (word_t'(inst_count) != inst_count_exp) begin
            $display("Mismatch new_inst count: expected %h, got %h",
                     inst_count_exp, word_t'(inst_count));
            errors++;
        end
        if (late_outputs != 0) begin
            $display("The output port fired %0d times after halt", late_outputs);
            errors++;
        end
        if (extra_outputs != 0) begin
            $display("The core wrote %0d more outputs than expected", extra_outputs);
            errors++;
        end
        report_test(test_name(NUM_SECTIONS), errors);
    endtask

    //////////////////////////////
    // Clock and memory model
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Read data follows the strobe by one cycle
    always @(posedge clk) begin
        if (reset_n && read_m) begin
            read_data <= mem[address[7:0]];
        end
        if (reset_n && write_m) begin
            mem[address[7:0]] <= write_data;
        end
    end

    //////////////////////////////
    // Monitors
    always @(posedge clk) begin
        // Sticky, so a core that drops out of halt is still caught
        if (reset_n && halted) begin
            halt_seen = 1'b1;
        end
        if (reset_n && new_inst) begin
            inst_count++;
        end
        if (reset_n && read_m) begin
            last_read_addr = address;
        end
        if (reset_n && output_valid) begin
            if (halt_seen) begin
                late_outputs++;
            end
            check_output(output_port);
        end
    end

    //////////////////////////////
    // Main sequence
    initial begin
        reset_n   <= 1'b0;
        read_data <= '0;
        load_image();
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        while (!halted) begin
            @(posedge clk);
        end
        // A few more cycles to catch stray outputs
        repeat (6) @(posedge clk);
        close_open_sections();
        check_halt();
        $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the core did not halt within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

// ==== sim/cpu_testdata.txt ====
// Hex words, up to sixteen per line, each block loaded from the address on the line above it
// 000 program image, 071 data, 100 expected wwd values ending in dead, 1f0 halt results
// Program: ALU and immediates, load and store, branches, jumps, hlt
@000
6112 5534 f41c 428f f81c f6c0 fc1c f6c1 fc1c f6c2 fc1c f6c3 fc1c f4c4 fc1c f4c5
fc1c f8c6 fc1c f8c7 fc1c 4360 8d10 7e10 f81c 7e11 f81c 610f 427a 6380 0001 f41c
f81c 0101 f41c f81c 1001 f41c f81c 1101 f41c f81c 2401 f41c f81c 2c01 f41c f81c
3c01 f41c f81c 3001 f41c f81c 9038 f41c a03a f41c f81c 433e fc19 f41c fc1c 4342
fc1a f41c f81c f01d
// Preloaded word for the second load
@071
beef
// Expected output_port values, 0f00 marks a fall-through and 007a a branch target
@100
1234 ff8f 11c3 12a5 1204 ffbf edcb edcc ff1e ffc7 1234 beef 0f00 007a 007a 007a
0f00 007a 007a 0f00 007a 007a 0f00 007a 0039 003e 0041 dead
// Halt address, instruction count, store address, stored word, outputs per test
@1f0
0043 003c 0070 1234 000a 0002 000c 0003
